//--- sources.f
source/wbuf_mem_pkg.sv
source/wbuf_entry_pkg.sv
source/wbuf_tx_if.sv
source/wbuf_store.sv
source/wbuf_issue.sv
source/wbuf_tx_tracker.sv
source/wbuf_top.sv
verification/wbuf_tb.sv

//--- Makefile
TOP = wbuf_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

//--- verification/wbuf_tb.sv
module wbuf_tb
  import wbuf_mem_pkg::*;
#(
  parameter int unsigned DEPTH  = 4,
  parameter int unsigned MAX_TX = 2
);

  localparam int unsigned ID_W         = (MAX_TX > 1) ? $clog2(MAX_TX) : 1;
  localparam int unsigned CLK_PERIOD   = 20;
  localparam int unsigned RESET_CYCLES = 5;
  localparam int unsigned NUM_TESTS    = 6;
  localparam int unsigned TEST_CYCLES  = 150;
  localparam int unsigned WAIT_CYCLES  = 50;

  logic              clk;
  logic              rst_n;
  logic              req;
  word_addr_t        addr;
  byte_en_t          be_w;
  word_data_t        wdata;
  logic              gnt;
  logic              empty;
  logic              mem_req;
  logic              mem_ack;
  logic [ADDR_W+1:0] mem_addr;
  mem_size_e         mem_size;
  word_data_t        mem_wdata;
  logic [ID_W-1:0]   mem_id;
  logic              rtrn_vld;
  logic [ID_W-1:0]   rtrn_id;

  // memory model, ids in the order memory accepted them
  logic [ID_W-1:0]   pending_ids[$];
  logic [ADDR_W+1:0] last_addr;
  mem_size_e         last_size;
  word_data_t        last_data;
  logic [31:0]       lfsr_q;

  wbuf_top #(.DEPTH(DEPTH), .MAX_TX(MAX_TX)) dut0 (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_i          (req),
    .addr_i         (addr),
    .be_i           (be_w),
    .wdata_i        (wdata),
    .gnt_o          (gnt),
    .empty_o        (empty),
    .mem_req_o      (mem_req),
    .mem_ack_i      (mem_ack),
    .mem_addr_o     (mem_addr),
    .mem_size_o     (mem_size),
    .mem_wdata_o    (mem_wdata),
    .mem_id_o       (mem_id),
    .mem_rtrn_vld_i (rtrn_vld),
    .mem_rtrn_id_i  (rtrn_id)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // helpers and checks
  //////////////////////////////

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_problem(string what);
    $display("ERROR at %0t: %s", $time, what);
    abort_run();
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_word(output word_data_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w      = {w[30:0], lfsr_q[31]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_size(string name, mem_size_e got, mem_size_e exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %s, expected %s", $time, name, got.name(), exp.name());
      abort_run();
    end
  endtask

  task automatic check_data(string name, word_data_t got, word_data_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(string name, logic [ADDR_W+1:0] got, logic [ADDR_W+1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_id(string name, logic [ID_W-1:0] got, logic [ID_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////
  // bus drivers
  //////////////////////////////

  // one request cycle, gnt_o is combinational so it is checked in the same cycle
  task automatic write_word(word_addr_t a, byte_en_t be, word_data_t d, logic exp_gnt);
    @(negedge clk);
    req   = 1'b1;
    addr  = a;
    be_w  = be;
    wdata = d;
    #1;
    check_bit("gnt_o", gnt, exp_gnt);
    @(negedge clk);
    req = 1'b0;
  endtask

  // ack stays up until the buffer offers a transfer
  task automatic take_transfer(output logic [ID_W-1:0] id);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    mem_ack = 1'b1;
    #1;
    while (!mem_req) begin
      waited++;
      if (waited > WAIT_CYCLES) begin
        report_problem("mem_req_o never rose for pending dirty data");
      end
      @(negedge clk);
      #1;
    end
    last_addr = mem_addr;
    last_size = mem_size;
    last_data = mem_wdata;
    id        = mem_id;
    pending_ids.push_back(mem_id);
    @(negedge clk);
    mem_ack = 1'b0;
  endtask

  // one-cycle write return for the oldest accepted transfer
  task automatic return_oldest();
    if (pending_ids.size() == 0) begin
      report_problem("return requested with no transfer outstanding");
    end
    @(negedge clk);
    rtrn_vld = 1'b1;
    rtrn_id  = pending_ids.pop_front();
    @(negedge clk);
    rtrn_vld = 1'b0;
  endtask

  task automatic wait_empty();
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    #1;
    while (!empty) begin
      waited++;
      if (waited > WAIT_CYCLES) begin
        report_problem("empty_o did not rise after the last return");
      end
      @(negedge clk);
      #1;
    end
  endtask

  // send and retire one transfer at a time until nothing is left
  task automatic drain_buffer(word_addr_t base);
    logic [ID_W-1:0] id;
    word_addr_t      wa;
    int unsigned     rounds;
    rounds = 0;
    while (!empty) begin
      rounds++;
      if (rounds > 4 * DEPTH) begin
        report_problem("buffer did not drain");
      end
      take_transfer(id);
      wa = last_addr[ADDR_W+1:2];
      if (wa < base || wa >= base + word_addr_t'(DEPTH)) begin
        report_problem("transfer to a word that was never written");
      end
      return_oldest();
      @(negedge clk);
      #1;
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_single_byte();
    word_data_t      w;
    word_addr_t      a;
    logic [ID_W-1:0] id;
    $display("test: single byte write");
    a = 30'h0000_1000;
    rand_word(w);
    write_word(a, 4'b0100, w, 1'b1);
    take_transfer(id);
    check_addr("mem_addr_o", last_addr, {a, 2'd2});
    check_size("mem_size_o", last_size, SIZE_BYTE);
    // lane 2 repeated on every lane
    check_data("mem_wdata_o", last_data, {4{w[23:16]}});
    return_oldest();
    wait_empty();
  endtask

  task automatic test_coalesce();
    word_data_t      w0;
    word_data_t      w1;
    word_addr_t      a;
    logic [ID_W-1:0] id;
    $display("test: coalescing");
    a = 30'h0000_2000;
    rand_word(w0);
    rand_word(w1);
    write_word(a, 4'b0011, w0, 1'b1);
    write_word(a, 4'b1100, w1, 1'b1);
    take_transfer(id);
    check_addr("mem_addr_o", last_addr, {a, 2'd0});
    check_size("mem_size_o", last_size, SIZE_WORD);
    check_data("mem_wdata_o", last_data, {w1[31:16], w0[15:0]});
    return_oldest();
    wait_empty();
  endtask

  task automatic test_unaligned_split();
    word_data_t      w;
    word_addr_t      a;
    logic [ID_W-1:0] id;
    $display("test: unaligned split");
    a = 30'h0000_3000;
    rand_word(w);
    write_word(a, 4'b1011, w, 1'b1);
    // low halfword first, lane 3 waits for the return
    take_transfer(id);
    check_addr("mem_addr_o", last_addr, {a, 2'd0});
    check_size("mem_size_o", last_size, SIZE_HALF);
    check_data("mem_wdata_o", last_data, {2{w[15:0]}});
    return_oldest();
    take_transfer(id);
    check_addr("mem_addr_o", last_addr, {a, 2'd3});
    check_size("mem_size_o", last_size, SIZE_BYTE);
    check_data("mem_wdata_o", last_data, {4{w[31:24]}});
    return_oldest();
    wait_empty();
  endtask

  task automatic test_back_pressure();
    word_data_t w;
    word_addr_t a;
    $display("test: back-pressure");
    a = 30'h0000_4000;
    for (int i = 0; i < DEPTH; i++) begin
      rand_word(w);
      write_word(a + word_addr_t'(i), 4'b0001, w, 1'b1);
    end
    // full, new word refused but a hit still merges
    write_word(a + word_addr_t'(DEPTH), 4'b0001, w, 1'b0);
    write_word(a, 4'b0010, w, 1'b1);
    drain_buffer(a);
  endtask

  task automatic test_rewrite_in_flight();
    word_data_t      w0;
    word_data_t      w1;
    word_addr_t      a;
    logic [ID_W-1:0] id;
    $display("test: rewrite in flight");
    a = 30'h0000_5000;
    rand_word(w0);
    rand_word(w1);
    write_word(a, 4'b0001, w0, 1'b1);
    take_transfer(id);
    check_data("mem_wdata_o", last_data, {4{w0[7:0]}});
    write_word(a, 4'b0001, w1, 1'b1);
    return_oldest();
    // byte went back to dirty, entry still held
    @(negedge clk);
    #1;
    check_bit("empty_o", empty, 1'b0);
    take_transfer(id);
    check_addr("mem_addr_o", last_addr, {a, 2'd0});
    check_size("mem_size_o", last_size, SIZE_BYTE);
    check_data("mem_wdata_o", last_data, {4{w1[7:0]}});
    return_oldest();
    wait_empty();
  endtask

  task automatic test_slot_limit();
    word_data_t      w;
    word_addr_t      a;
    logic [ID_W-1:0] id;
    $display("test: slot limit");
    a = 30'h0000_6000;
    for (int i = 0; i <= MAX_TX + 1; i++) begin
      rand_word(w);
      write_word(a + word_addr_t'(i), 4'b0001, w, 1'b1);
    end
    // a retired id is offered again before any higher one
    take_transfer(id);
    check_id("mem_id_o", id, '0);
    return_oldest();
    // ids handed out lowest first
    for (int i = 0; i < MAX_TX; i++) begin
      take_transfer(id);
      check_id("mem_id_o", id, ID_W'(i));
    end
    repeat (3) begin
      @(negedge clk);
      #1;
      check_bit("mem_req_o", mem_req, 1'b0);
    end
    check_bit("empty_o", empty, 1'b0);
    return_oldest();
    take_transfer(id);
    check_id("mem_id_o", id, '0);
    while (pending_ids.size() != 0) begin
      return_oldest();
    end
    wait_empty();
  endtask

  //////////////////////////////
  // sequence and watchdog
  //////////////////////////////

  initial begin : main
    rst_n    = 1'b0;
    req      = 1'b0;
    addr     = '0;
    be_w     = '0;
    wdata    = '0;
    mem_ack  = 1'b0;
    rtrn_vld = 1'b0;
    rtrn_id  = '0;
    lfsr_q   = 32'h34c0_71c8;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_bit("gnt_o", gnt, 1'b0);
    check_bit("mem_req_o", mem_req, 1'b0);
    check_bit("empty_o", empty, 1'b1);
    test_single_byte();
    test_coalesce();
    test_unaligned_split();
    test_back_pressure();
    test_rewrite_in_flight();
    test_slot_limit();
    $display("All tests passed");
    $finish;
  end

  // budget covers reset plus every test at its worst case
  initial begin : watchdog
    #((NUM_TESTS * TEST_CYCLES + RESET_CYCLES) * CLK_PERIOD);
    report_problem("watchdog expired before the tests finished");
  end

endmodule

//--- source/wbuf_top.sv
module wbuf_top
  import wbuf_mem_pkg::*;
  import wbuf_entry_pkg::*;
#(
  parameter  int unsigned DEPTH  = 4,
  parameter  int unsigned MAX_TX = 2,
  localparam int unsigned ID_W   = (MAX_TX > 1) ? $clog2(MAX_TX) : 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // core store port
  input  logic              req_i,
  input  word_addr_t        addr_i,
  input  byte_en_t          be_i,
  input  word_data_t        wdata_i,
  output logic              gnt_o,
  output logic              empty_o,
  // memory write port
  output logic              mem_req_o,
  input  logic              mem_ack_i,
  output logic [ADDR_W+1:0] mem_addr_o,
  output mem_size_e         mem_size_o,
  output word_data_t        mem_wdata_o,
  output logic [ID_W-1:0]   mem_id_o,
  input  logic              mem_rtrn_vld_i,
  input  logic [ID_W-1:0]   mem_rtrn_id_i
);

  // rr select relies on natural pointer wrap
  if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
    $error("wbuf_top: DEPTH must be a power of two of at least 2");
  end

  wbuf_entry_t [DEPTH-1:0] entries;
  logic                    slot_free;

  wbuf_tx_if #(.DEPTH(DEPTH)) tx_if ();

  wbuf_store #(.DEPTH(DEPTH)) i_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .addr_i    (addr_i),
    .be_i      (be_i),
    .wdata_i   (wdata_i),
    .gnt_o     (gnt_o),
    .empty_o   (empty_o),
    .entries_o (entries),
    .tx        (tx_if.store)
  );

  wbuf_issue #(.DEPTH(DEPTH)) i_issue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .entries_i   (entries),
    .slot_free_i (slot_free),
    .mem_req_o   (mem_req_o),
    .mem_ack_i   (mem_ack_i),
    .mem_addr_o  (mem_addr_o),
    .mem_size_o  (mem_size_o),
    .mem_wdata_o (mem_wdata_o),
    .tx          (tx_if.issue)
  );

  wbuf_tx_tracker #(.DEPTH(DEPTH), .MAX_TX(MAX_TX)) i_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slot_free_o    (slot_free),
    .mem_id_o       (mem_id_o),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .mem_rtrn_id_i  (mem_rtrn_id_i),
    .tx             (tx_if.tracker)
  );

endmodule

//--- source/wbuf_tx_tracker.sv
module wbuf_tx_tracker
  import wbuf_mem_pkg::*;
#(
  parameter  int unsigned DEPTH  = 4,
  parameter  int unsigned MAX_TX = 2,
  localparam int unsigned ID_W   = (MAX_TX > 1) ? $clog2(MAX_TX) : 1
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  output logic            slot_free_o,
  output logic [ID_W-1:0] mem_id_o,
  input  logic            mem_rtrn_vld_i,
  input  logic [ID_W-1:0] mem_rtrn_id_i,
  wbuf_tx_if.tracker      tx
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(MAX_TX + 1);

  // slot table, one per transaction id
  logic [MAX_TX-1:0] slot_vld_q;
  logic [PTR_W-1:0]  slot_ptr_q [MAX_TX];
  byte_en_t          slot_be_q  [MAX_TX];
  logic [ID_W-1:0]   free_id;

  // return id fifo, registered head
  logic [ID_W-1:0]   fifo_q [MAX_TX];
  logic [ID_W-1:0]   fifo_wr_q;
  logic [ID_W-1:0]   fifo_rd_q;
  logic [CNT_W-1:0]  fifo_cnt_q;
  logic              fifo_full;
  logic              push;
  logic              evict;
  logic [ID_W-1:0]   head_id;

  function automatic logic [ID_W-1:0] ptr_inc(logic [ID_W-1:0] p);
    return (p == ID_W'(MAX_TX - 1)) ? '0 : p + 1'b1;
  endfunction

  //////////////////////////////
  // slot allocation
  //////////////////////////////

  // lowest free id is offered
  always_comb begin : p_free
    free_id = '0;
    for (int i = MAX_TX - 1; i >= 0; i--) begin
      if (!slot_vld_q[i]) begin
        free_id = ID_W'(i);
      end
    end
  end

  assign slot_free_o = ~&slot_vld_q;
  assign mem_id_o    = free_id;

  // send takes a free slot, evict releases a busy one
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_slot_vld
    if (!rst_ni) begin
      slot_vld_q <= '0;
    end else begin
      if (evict) begin
        slot_vld_q[head_id] <= 1'b0;
      end
      if (tx.send) begin
        slot_vld_q[free_id] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_slot_data
    if (tx.send) begin
      slot_ptr_q[free_id] <= tx.send_ptr;
      slot_be_q[free_id]  <= tx.send_be;
    end
  end

  //////////////////////////////
  // return fifo and eviction
  //////////////////////////////

  assign fifo_full = (fifo_cnt_q == CNT_W'(MAX_TX));
  assign push      = mem_rtrn_vld_i && !fifo_full;
  assign head_id   = fifo_q[fifo_rd_q];
  // one eviction per cycle while ids are queued
  assign evict     = (fifo_cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_fifo_ctrl
    if (!rst_ni) begin
      fifo_wr_q  <= '0;
      fifo_rd_q  <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (push) begin
        fifo_wr_q <= ptr_inc(fifo_wr_q);
      end
      if (evict) begin
        fifo_rd_q <= ptr_inc(fifo_rd_q);
      end
      fifo_cnt_q <= fifo_cnt_q + CNT_W'(push) - CNT_W'(evict);
    end
  end

  always_ff @(posedge clk_i) begin : p_fifo_data
    if (push) begin
      fifo_q[fifo_wr_q] <= mem_rtrn_id_i;
    end
  end

  assign tx.evict     = evict;
  assign tx.evict_ptr = slot_ptr_q[head_id];
  assign tx.evict_be  = slot_be_q[head_id];

  // memory must only return ids that were sent and not yet retired
  a_evict_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evict |-> slot_vld_q[head_id])
    else $error("wbuf_tx_tracker: eviction of an idle slot");

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rtrn_vld_i |-> !fifo_full)
    else $error("wbuf_tx_tracker: return while id fifo is full");

endmodule

//--- source/wbuf_issue.sv
module wbuf_issue
  import wbuf_mem_pkg::*;
  import wbuf_entry_pkg::*;
#(
  parameter int unsigned DEPTH = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  wbuf_entry_t [DEPTH-1:0] entries_i,
  input  logic                    slot_free_i,
  output logic                    mem_req_o,
  input  logic                    mem_ack_i,
  output logic [ADDR_W+1:0]       mem_addr_o,
  output mem_size_e               mem_size_o,
  output word_data_t              mem_wdata_o,
  wbuf_tx_if.issue                tx
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  byte_en_t [DEPTH-1:0] sendable;
  logic     [DEPTH-1:0] has_dirty;
  logic     [PTR_W-1:0] rr_q;
  logic     [PTR_W-1:0] sel_ptr;
  wbuf_entry_t          sel_entry;
  byte_en_t             sel_be;
  byte_off_t            byte_off;
  logic                 send;

  for (genvar k = 0; k < DEPTH; k++) begin : g_sendable
    assign sendable[k]  = sendable_be(entries_i[k]);
    assign has_dirty[k] = |sendable[k];
  end

  //////////////////////////////
  // entry select
  //////////////////////////////

  // first dirty entry at or after the rr pointer, wraps on power of two
  always_comb begin : p_select
    logic [PTR_W-1:0] idx;
    logic             found;
    sel_ptr = rr_q;
    found   = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      idx = rr_q + PTR_W'(i);
      if (!found && has_dirty[idx]) begin
        sel_ptr = idx;
        found   = 1'b1;
      end
    end
  end

  assign sel_entry = entries_i[sel_ptr];
  assign sel_be    = sendable[sel_ptr];

  //////////////////////////////
  // aligned transfer
  //////////////////////////////

  always_comb begin : p_size
    byte_off = '0;
    // lowest sendable lane sets the offset
    for (int j = WORD_BYTES - 1; j >= 0; j--) begin
      if (sel_be[j]) begin
        byte_off = byte_off_t'(j);
      end
    end
    if (&sel_be) begin
      mem_size_o = SIZE_WORD;
    end else if (!byte_off[0] && sel_be[{byte_off[1], 1'b1}]) begin
      // even offset with its upper neighbour pending
      mem_size_o = SIZE_HALF;
    end else begin
      mem_size_o = SIZE_BYTE;
    end
  end

  // needs dirty data and a free transaction id
  assign mem_req_o   = (|has_dirty) && slot_free_i;
  assign mem_addr_o  = {sel_entry.wtag, byte_off};
  assign mem_wdata_o = replicate(sel_entry.data, byte_off, mem_size_o);

  assign send        = mem_req_o && mem_ack_i;
  assign tx.send     = send;
  assign tx.send_ptr = sel_ptr;
  assign tx.send_be  = size_to_be(byte_off, mem_size_o);

  // move past the served entry
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (send) begin
      rr_q <= sel_ptr + 1'b1;
    end
  end

  // memory stall holds the transfer unless the core changed the dirty bytes
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_ack_i) ##1 (mem_req_o && $stable(sendable))
      |-> ($stable(mem_size_o) && $stable(byte_off)))
    else $error("wbuf_issue: transfer changed while stalled");

endmodule

//--- source/wbuf_store.sv
module wbuf_store
  import wbuf_mem_pkg::*;
  import wbuf_entry_pkg::*;
#(
  parameter int unsigned DEPTH = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  word_addr_t              addr_i,
  input  byte_en_t                be_i,
  input  word_data_t              wdata_i,
  output logic                    gnt_o,
  output logic                    empty_o,
  output wbuf_entry_t [DEPTH-1:0] entries_o,
  wbuf_tx_if.store                tx
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  word_addr_t [DEPTH-1:0] tag_d, tag_q;
  word_data_t [DEPTH-1:0] data_d, data_q;
  byte_en_t   [DEPTH-1:0] valid_d, valid_q;
  byte_en_t   [DEPTH-1:0] dirty_d, dirty_q;
  byte_en_t   [DEPTH-1:0] txblock_d, txblock_q;

  logic [DEPTH-1:0] used;
  logic [DEPTH-1:0] hit_oh;
  logic             hit;
  logic             full;
  logic [PTR_W-1:0] hit_ptr;
  logic [PTR_W-1:0] free_ptr;
  logic [PTR_W-1:0] wr_ptr;

  //////////////////////////////
  // lookup
  //////////////////////////////

  // walk downwards so the lowest index wins
  always_comb begin : p_lookup
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = DEPTH - 1; k >= 0; k--) begin
      used[k]   = |valid_q[k];
      hit_oh[k] = used[k] && (tag_q[k] == addr_i);
      if (hit_oh[k]) begin
        hit_ptr = PTR_W'(k);
      end
      if (!used[k]) begin
        free_ptr = PTR_W'(k);
      end
    end
  end

  assign hit     = |hit_oh;
  assign full    = &used;
  // coalesce into a matching word, else take a free slot
  assign wr_ptr  = hit ? hit_ptr : free_ptr;
  assign gnt_o   = req_i && (hit || !full);
  assign empty_o = ~|used;

  //////////////////////////////
  // byte state update
  //////////////////////////////

  always_comb begin : p_update
    tag_d     = tag_q;
    data_d    = data_q;
    valid_d   = valid_q;
    dirty_d   = dirty_q;
    txblock_d = txblock_q;

    // return retired, untouched bytes are freed
    // and rewritten ones stay dirty for a resend
    if (tx.evict) begin
      for (int j = 0; j < WORD_BYTES; j++) begin
        if (tx.evict_be[j]) begin
          txblock_d[tx.evict_ptr][j] = 1'b0;
          if (!dirty_q[tx.evict_ptr][j]) begin
            valid_d[tx.evict_ptr][j] = 1'b0;
          end
        end
      end
    end

    // accepted transfer moves bytes into flight
    if (tx.send) begin
      for (int j = 0; j < WORD_BYTES; j++) begin
        if (tx.send_be[j]) begin
          dirty_d[tx.send_ptr][j]   = 1'b0;
          txblock_d[tx.send_ptr][j] = 1'b1;
        end
      end
    end

    // core write comes last and may re-dirty a byte in flight
    if (gnt_o) begin
      tag_d[wr_ptr] = addr_i;
      for (int j = 0; j < WORD_BYTES; j++) begin
        if (be_i[j]) begin
          valid_d[wr_ptr][j]                 = 1'b1;
          dirty_d[wr_ptr][j]                 = 1'b1;
          data_d[wr_ptr][BYTE_W*j +: BYTE_W] = wdata_i[BYTE_W*j +: BYTE_W];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      valid_q   <= '0;
      dirty_q   <= '0;
      txblock_q <= '0;
    end else begin
      valid_q   <= valid_d;
      dirty_q   <= dirty_d;
      txblock_q <= txblock_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    tag_q  <= tag_d;
    data_q <= data_d;
  end

  for (genvar k = 0; k < DEPTH; k++) begin : g_entries
    assign entries_o[k] = '{
      wtag:    tag_q[k],
      data:    data_q[k],
      valid:   valid_q[k],
      dirty:   dirty_q[k],
      txblock: txblock_q[k]
    };
  end

  //////////////////////////////
  // assertions
  //////////////////////////////

  // coalescing keeps each word address in one entry only
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> $onehot0(hit_oh))
    else $error("wbuf_store: address hits more than one entry");

  // a miss may only fill an entry that holds no bytes
  a_no_gnt_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt_o && !hit) |-> !used[wr_ptr])
    else $error("wbuf_store: write granted into a full buffer");

  // send and evict together must keep every byte in a legal state
  for (genvar k = 0; k < DEPTH; k++) begin : g_chk_entry
    for (genvar j = 0; j < WORD_BYTES; j++) begin : g_chk_byte
      a_byte_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
        byte_legal(entries_o[k], j))
        else $error("wbuf_store: entry %0d byte %0d in illegal state", k, j);
    end
  end

endmodule

//--- source/wbuf_tx_if.sv
interface wbuf_tx_if
  import wbuf_mem_pkg::*;
#(
  parameter int unsigned DEPTH = 4
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  // transfer accepted by memory this cycle
  logic             send;
  logic [PTR_W-1:0] send_ptr;
  byte_en_t         send_be;

  // write return retired, bytes leave flight
  logic             evict;
  logic [PTR_W-1:0] evict_ptr;
  byte_en_t         evict_be;

  // entry array sees both event groups
  modport store (
    input send, send_ptr, send_be,
    input evict, evict_ptr, evict_be
  );

  modport issue (
    output send, send_ptr, send_be
  );

  // tracker records sends and raises evictions
  modport tracker (
    output evict, evict_ptr, evict_be,
    input  send, send_ptr, send_be
  );

endinterface

//--- source/wbuf_entry_pkg.sv
package wbuf_entry_pkg;

  import wbuf_mem_pkg::*;

  // one word slot of the buffer, state kept per byte
  typedef struct packed {
    word_addr_t wtag;
    word_data_t data;
    byte_en_t   valid;
    byte_en_t   dirty;
    byte_en_t   txblock;
  } wbuf_entry_t;

  // legal {valid, dirty, txblock} combinations
  typedef enum logic [2:0] {
    BS_FREE     = 3'b000,
    BS_DIRTY    = 3'b110,
    BS_INFLIGHT = 3'b101,
    BS_REWRITE  = 3'b111
  } byte_state_e;

  function automatic byte_state_e byte_state(wbuf_entry_t e, int unsigned k);
    return byte_state_e'({e.valid[k], e.dirty[k], e.txblock[k]});
  endfunction

  // 1/0/0 and the other leftovers never show up
  function automatic logic byte_legal(wbuf_entry_t e, int unsigned k);
    byte_state_e s;
    s = byte_state(e, k);
    return s inside {BS_FREE, BS_DIRTY, BS_INFLIGHT, BS_REWRITE};
  endfunction

  // an entry with any byte in flight is held back,
  // transfers to one word must not overtake each other
  function automatic byte_en_t sendable_be(wbuf_entry_t e);
    return (|e.txblock) ? '0 : (e.valid & e.dirty);
  endfunction

endpackage

//--- source/wbuf_mem_pkg.sv
package wbuf_mem_pkg;

  // word geometry of the memory side
  localparam int unsigned WORD_BYTES = 4;
  localparam int unsigned BYTE_W     = 8;
  localparam int unsigned WORD_W     = WORD_BYTES * BYTE_W;
  localparam int unsigned ADDR_W     = 30;

  typedef logic [WORD_W-1:0]     word_data_t;
  typedef logic [WORD_BYTES-1:0] byte_en_t;
  typedef logic [ADDR_W-1:0]     word_addr_t;
  typedef logic [1:0]            byte_off_t;

  // naturally aligned transfer sizes on the memory port
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

  // byte lanes covered by one aligned transfer
  function automatic byte_en_t size_to_be(byte_off_t off, mem_size_e size);
    byte_en_t be;
    be = '0;
    case (size)
      SIZE_BYTE: be[off] = 1'b1;
      SIZE_HALF: be[off +: 2] = 2'b11;
      default:   be = '1;
    endcase
    return be;
  endfunction

  // short transfers repeat their lanes over the whole bus
  function automatic word_data_t replicate(word_data_t data, byte_off_t off, mem_size_e size);
    word_data_t rep;
    case (size)
      SIZE_BYTE: rep = {WORD_BYTES{data[BYTE_W*off +: BYTE_W]}};
      SIZE_HALF: rep = {2{data[BYTE_W*off +: 2*BYTE_W]}};
      default:   rep = data;
    endcase
    return rep;
  endfunction

endpackage
